//--- batrider_bus.f
logic/batrider_pkg.sv
logic/bus_decoder.sv
logic/ram_bank.sv
logic/io_regs.sv
logic/read_mux.sv
logic/batrider_bus.sv
test/batrider_bus_props.sv
test/bus_checker.sv
test/tb_batrider_bus.sv

//--- logic/batrider_bus.sv
`timescale 1ns/1ps

module batrider_bus (
    input  logic                    CLK96,
    input  logic                    RESET96,
    input  batrider_pkg::cpu_bus_t  bus,
    output batrider_pkg::data_t     rdata,
    input  batrider_pkg::joy_t      joy1,
    input  batrider_pkg::joy_t      joy2,
    input  logic [1:0]              start,
    input  logic [1:0]              coin,
    input  logic                    service,
    input  logic                    dip_test,
    input  batrider_pkg::byte_t     dipsw_a,
    input  batrider_pkg::byte_t     dipsw_b,
    input  batrider_pkg::byte_t     dipsw_c,
    input  batrider_pkg::video_in_t video,
    input  batrider_pkg::byte_t     slatch3_in,
    input  batrider_pkg::byte_t     slatch4_in,
    output batrider_pkg::byte_t     slatch,
    output batrider_pkg::byte_t     slatch2,
    output batrider_pkg::gcu_op_t   gcu_op,
    input  logic                    gcu_ack,
    input  batrider_pkg::data_t     gcu_dout,
    output logic                    text_dma_w,
    output logic                    pal_dma_w,
    input  logic                    tvram_busy
);
    import batrider_pkg::*;

    bus_req_t                  req;
    logic [NUM_RAM_BANKS-1:0]  bank_sel;
    data_t [NUM_RAM_BANKS-1:0] bank_q;
    data_t                     busreq_word;    // z80 bus request, read back at 0x0c

    bus_decoder u_decoder (
        .CLK96    (CLK96),
        .RESET96  (RESET96),
        .bus      (bus),
        .req      (req),
        .bank_sel (bank_sel)
    );

    // vram and work ram
    for (genvar b = 0; b < NUM_RAM_BANKS; b++) begin : g_bank
        ram_bank u_bank (
            .CLK96 (CLK96),
            .sel   (bank_sel[b]),
            .req   (req),
            .q     (bank_q[b])
        );
    end

    io_regs u_io (
        .CLK96       (CLK96),
        .RESET96     (RESET96),
        .req         (req),
        .gcu_ack     (gcu_ack),
        .tvram_busy  (tvram_busy),
        .slatch      (slatch),
        .slatch2     (slatch2),
        .busreq_word (busreq_word),
        .gcu_op      (gcu_op),
        .text_dma_w  (text_dma_w),
        .pal_dma_w   (pal_dma_w)
    );

    read_mux u_rmux (
        .CLK96       (CLK96),
        .RESET96     (RESET96),
        .req         (req),
        .bank_q      (bank_q),
        .gcu_dout    (gcu_dout),
        .joy1        (joy1),
        .joy2        (joy2),
        .start       (start),
        .coin        (coin),
        .service     (service),
        .dip_test    (dip_test),
        .dipsw_a     (dipsw_a),
        .dipsw_b     (dipsw_b),
        .dipsw_c     (dipsw_c),
        .video       (video),
        .slatch3_in  (slatch3_in),
        .slatch4_in  (slatch4_in),
        .busreq_word (busreq_word),
        .rdata       (rdata)
    );

endmodule

//--- logic/batrider_pkg.sv
package batrider_pkg;

    typedef logic [23:1] word_addr_t;   // 68k word address
    typedef logic [15:0] data_t;
    typedef logic [7:0]  byte_t;
    typedef logic [13:0] ram_addr_t;    // word index inside one bank
    typedef logic [6:0]  joy_t;         // active low, 3..0 dirs, 6..4 buttons

    localparam int NUM_RAM_BANKS = 2;
    localparam int VRAM_BANK     = 0;   // 0x200000-0x207fff
    localparam int WRAM_BANK     = 1;   // 0x208000-0x20ffff
    localparam int RAM_WORDS     = 16384;
    localparam int BANK_BIT      = 15;  // byte address bit that splits the banks

    // region pages, compared against addr[23:16]
    localparam byte_t RAM_PAGE = 8'h20;
    localparam byte_t GCU_PAGE = 8'h40;
    localparam byte_t IO_PAGE  = 8'h50;

    // byte offsets in the i/o page
    localparam byte_t IO_CTRL      = 8'h00;
    localparam byte_t IO_SYS_DSW   = 8'h02;
    localparam byte_t IO_DSW_AB    = 8'h04;
    localparam byte_t IO_VSTATUS   = 8'h06;
    localparam byte_t IO_SLATCH3   = 8'h08;
    localparam byte_t IO_SLATCH4   = 8'h0A;
    localparam byte_t IO_BUSREQ_RD = 8'h0C;
    localparam byte_t IO_SLATCH_W  = 8'h20;
    localparam byte_t IO_SLATCH2_W = 8'h22;
    localparam byte_t IO_BUSREQ_W  = 8'h60;
    localparam byte_t IO_TEXT_DMA  = 8'h80;
    localparam byte_t IO_PAL_DMA   = 8'h82;

    // gcu register offsets
    localparam logic [3:0] GCU_WRITE_REG  = 4'h0;
    localparam logic [3:0] GCU_SELECT_REG = 4'h4;
    localparam logic [3:0] GCU_RAM_H      = 4'h8;
    localparam logic [3:0] GCU_RAM_L      = 4'hA;
    localparam logic [3:0] GCU_RAM_PTR    = 4'hC;

    typedef struct packed {
        logic       as;
        logic       rw;     // 1 = read
        logic       uds;
        logic       lds;
        word_addr_t addr;
        data_t      wdata;
    } cpu_bus_t;

    // one bit per i/o page register
    typedef struct packed {
        logic ctrl;
        logic sys_dsw;
        logic dsw_ab;
        logic vstatus;
        logic slatch3;
        logic slatch4;
        logic busreq_rd;
        logic slatch_w;
        logic slatch2_w;
        logic busreq_w;
        logic text_dma;
        logic pal_dma;
    } io_sel_t;

    typedef struct packed {
        cpu_bus_t bus;
        logic     sel_ram;
        logic     sel_gcu;
        logic     sel_io;
        io_sel_t  io_sel;
    } bus_req_t;

    typedef struct packed {
        logic select_reg;
        logic write_reg;
        logic write_ram;
        logic read_ram_h;
        logic read_ram_l;
        logic set_ram_ptr;
    } gcu_op_t;

    typedef struct packed {
        logic       hsync;
        logic       vsync;
        logic       fblank;
        logic [8:0] v;      // line count
    } video_in_t;

endpackage

//--- logic/bus_decoder.sv
`timescale 1ns/1ps

module bus_decoder (
    input  logic                                  CLK96,
    input  logic                                  RESET96,
    input  batrider_pkg::cpu_bus_t                bus,
    output batrider_pkg::bus_req_t                req,
    output logic [batrider_pkg::NUM_RAM_BANKS-1:0] bank_sel
);
    import batrider_pkg::*;

    byte_t   page;
    byte_t   io_off;
    logic    ram_hit;
    logic    gcu_hit;
    logic    io_hit;
    io_sel_t io_sel_nxt;

    always_comb begin
        page    = bus.addr[23:16];
        io_off  = {bus.addr[7:1], 1'b0};   // back to a byte offset
        ram_hit = (page == RAM_PAGE);      // both banks, 0x200000-0x20ffff
        gcu_hit = (page == GCU_PAGE);
        io_hit  = (page == IO_PAGE);

        io_sel_nxt.ctrl      = io_hit && (io_off == IO_CTRL);
        io_sel_nxt.sys_dsw   = io_hit && (io_off == IO_SYS_DSW);
        io_sel_nxt.dsw_ab    = io_hit && (io_off == IO_DSW_AB);
        io_sel_nxt.vstatus   = io_hit && (io_off == IO_VSTATUS);
        io_sel_nxt.slatch3   = io_hit && (io_off == IO_SLATCH3);
        io_sel_nxt.slatch4   = io_hit && (io_off == IO_SLATCH4);
        io_sel_nxt.busreq_rd = io_hit && (io_off == IO_BUSREQ_RD);
        io_sel_nxt.slatch_w  = io_hit && (io_off == IO_SLATCH_W);
        io_sel_nxt.slatch2_w = io_hit && (io_off == IO_SLATCH2_W);
        io_sel_nxt.busreq_w  = io_hit && (io_off == IO_BUSREQ_W);
        io_sel_nxt.text_dma  = io_hit && (io_off == IO_TEXT_DMA);
        io_sel_nxt.pal_dma   = io_hit && (io_off == IO_PAL_DMA);
    end

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            req      <= '0;
            bank_sel <= '0;
        end else if (bus.as) begin
            req.bus     <= bus;
            req.sel_ram <= ram_hit;
            req.sel_gcu <= gcu_hit;
            req.sel_io  <= io_hit;
            req.io_sel  <= io_sel_nxt;
            bank_sel[VRAM_BANK] <= ram_hit && !bus.addr[BANK_BIT];
            bank_sel[WRAM_BANK] <= ram_hit && bus.addr[BANK_BIT];
        end else begin
            // idle bus, keep the payload but drop every select
            req.bus.as  <= 1'b0;
            req.sel_ram <= 1'b0;
            req.sel_gcu <= 1'b0;
            req.sel_io  <= 1'b0;
            req.io_sel  <= '0;
            bank_sel    <= '0;
        end
    end

endmodule

//--- logic/io_regs.sv
`timescale 1ns/1ps

module io_regs (
    input  logic                   CLK96,
    input  logic                   RESET96,
    input  batrider_pkg::bus_req_t req,
    input  logic                   gcu_ack,
    input  logic                   tvram_busy,
    output batrider_pkg::byte_t    slatch,
    output batrider_pkg::byte_t    slatch2,
    output batrider_pkg::data_t    busreq_word,
    output batrider_pkg::gcu_op_t  gcu_op,
    output logic                   text_dma_w,
    output logic                   pal_dma_w
);
    import batrider_pkg::*;

    logic       io_wr;
    logic       any_io_gcu;
    logic       any_sel;
    logic [3:0] gcu_off;
    gcu_op_t    gcu_set;    // ops requested by this cycle

    always_comb begin
        io_wr      = req.sel_io && !req.bus.rw;
        any_io_gcu = req.sel_io || req.sel_gcu;
        any_sel    = any_io_gcu || req.sel_ram;
        gcu_off    = {req.bus.addr[3:1], 1'b0};
        gcu_set    = '0;
        if (req.sel_gcu) begin
            if (req.bus.rw) begin
                case (gcu_off)
                    GCU_RAM_H: gcu_set.read_ram_h = 1'b1;
                    GCU_RAM_L: gcu_set.read_ram_l = 1'b1;
                    default:   gcu_set = '0;
                endcase
            end else begin
                case (gcu_off)
                    GCU_WRITE_REG:        gcu_set.write_reg   = 1'b1;
                    GCU_SELECT_REG:       gcu_set.select_reg  = 1'b1;
                    GCU_RAM_H, GCU_RAM_L: gcu_set.write_ram   = 1'b1;
                    GCU_RAM_PTR:          gcu_set.set_ram_ptr = 1'b1;
                    default:              gcu_set = '0;
                endcase
            end
        end
    end

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            slatch      <= '0;
            slatch2     <= '0;
            busreq_word <= '0;
            gcu_op      <= '0;
            text_dma_w  <= 1'b0;
            pal_dma_w   <= 1'b0;
        end else begin
            // sound latches take the low byte only
            if (io_wr && req.io_sel.slatch_w)
                slatch <= req.bus.wdata[7:0];
            if (io_wr && req.io_sel.slatch2_w)
                slatch2 <= req.bus.wdata[7:0];
            if (io_wr && req.io_sel.busreq_w)
                busreq_word <= req.bus.wdata;

            // held until the gcu acks with the bus quiet
            if (gcu_ack && !any_io_gcu)
                gcu_op <= '0;
            else
                gcu_op <= gcu_op_t'(gcu_op | gcu_set);

            if (io_wr && req.io_sel.text_dma)
                text_dma_w <= 1'b1;
            else if (!tvram_busy && !any_sel)
                text_dma_w <= 1'b0;     // text ram controller idle

            if (io_wr && req.io_sel.pal_dma)
                pal_dma_w <= 1'b1;
            else if (!tvram_busy && !any_sel)
                pal_dma_w <= 1'b0;
        end
    end

endmodule

//--- logic/ram_bank.sv
`timescale 1ns/1ps

module ram_bank (
    input  logic                   CLK96,
    input  logic                   sel,
    input  batrider_pkg::bus_req_t req,
    output batrider_pkg::data_t    q
);
    import batrider_pkg::*;

    // separate byte lanes
    byte_t     mem_hi [RAM_WORDS];
    byte_t     mem_lo [RAM_WORDS];
    ram_addr_t word_idx;
    logic      wr;

    assign word_idx = req.bus.addr[BANK_BIT-1:1];
    assign wr       = sel && !req.bus.rw;

    always_ff @(posedge CLK96) begin
        if (wr && req.bus.uds)
            mem_hi[word_idx] <= req.bus.wdata[15:8];
        if (wr && req.bus.lds)
            mem_lo[word_idx] <= req.bus.wdata[7:0];
        q <= {mem_hi[word_idx], mem_lo[word_idx]};   // read every cycle, old data on a write
    end

endmodule

//--- logic/read_mux.sv
`timescale 1ns/1ps

module read_mux (
    input  logic                                                 CLK96,
    input  logic                                                 RESET96,
    input  batrider_pkg::bus_req_t                               req,
    input  batrider_pkg::data_t [batrider_pkg::NUM_RAM_BANKS-1:0] bank_q,
    input  batrider_pkg::data_t                                  gcu_dout,
    input  batrider_pkg::joy_t                                   joy1,
    input  batrider_pkg::joy_t                                   joy2,
    input  logic [1:0]                                           start,
    input  logic [1:0]                                           coin,
    input  logic                                                 service,
    input  logic                                                 dip_test,
    input  batrider_pkg::byte_t                                  dipsw_a,
    input  batrider_pkg::byte_t                                  dipsw_b,
    input  batrider_pkg::byte_t                                  dipsw_c,
    input  batrider_pkg::video_in_t                              video,
    input  batrider_pkg::byte_t                                  slatch3_in,
    input  batrider_pkg::byte_t                                  slatch4_in,
    input  batrider_pkg::data_t                                  busreq_word,
    output batrider_pkg::data_t                                  rdata
);
    import batrider_pkg::*;

    bus_req_t req_d;    // lines up with bank_q
    byte_t    p1_ctrl;
    byte_t    p2_ctrl;
    byte_t    sys_lo;
    byte_t    vcount;
    data_t    vstatus;
    data_t    rdata_nxt;

    // inputs come in active low, the game wants active high
    function automatic byte_t ctrl_byte(input joy_t j);
        return {1'b0, ~j[6], ~j[5], ~j[4], ~j[0], ~j[1], ~j[2], ~j[3]};
    endfunction

    always_comb begin
        p1_ctrl = ctrl_byte(joy1);
        p2_ctrl = ctrl_byte(joy2);
        sys_lo  = {1'b0, ~start[1], ~start[0], ~coin[1], ~coin[0], ~dip_test, 1'b0, ~service};
        vcount  = video.v[8] ? 8'hFF : video.v[7:0];   // saturates past line 255
        vstatus = {video.hsync, video.vsync, 5'b11111, video.fblank, vcount};

        if (req_d.sel_gcu && req_d.bus.rw)
            rdata_nxt = gcu_dout;
        else if (req_d.sel_ram)
            rdata_nxt = bank_q[req_d.bus.addr[BANK_BIT]];
        else if (req_d.io_sel.ctrl)
            rdata_nxt = {p2_ctrl, p1_ctrl};
        else if (req_d.io_sel.sys_dsw)
            rdata_nxt = {dipsw_c, sys_lo};
        else if (req_d.io_sel.dsw_ab)
            rdata_nxt = {dipsw_b, dipsw_a};
        else if (req_d.io_sel.vstatus)
            rdata_nxt = vstatus;
        else if (req_d.io_sel.slatch3)
            rdata_nxt = {8'h00, slatch3_in};
        else if (req_d.io_sel.slatch4)
            rdata_nxt = {8'h00, slatch4_in};
        else if (req_d.io_sel.busreq_rd)
            rdata_nxt = busreq_word;
        else
            rdata_nxt = '0;     // unmapped or write-only
    end

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            req_d <= '0;
            rdata <= '0;
        end else begin
            req_d <= req;
            rdata <= rdata_nxt;
        end
    end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the batrider_bus testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f batrider_bus.f \
    --top-module tb_batrider_bus -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/Vtb_batrider_bus > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Done: errors found" sim.log; then
    exit 1
fi
exit 0

//--- test/batrider_bus_props.sv
`timescale 1ns/1ps

module batrider_bus_props (
    input logic                  CLK96,
    input logic                  RESET96,
    input logic                  gcu_ack,
    input logic                  tvram_busy,
    input batrider_pkg::gcu_op_t gcu_op,
    input logic                  text_dma_w,
    input logic                  pal_dma_w
);
    import batrider_pkg::*;

    int fail_count = 0;    // read by the testbench at the end of the run

    // strobes come out of reset cleared
    a_reset_clear: assert property (@(posedge CLK96)
        $fell(RESET96) |-> (gcu_op == '0 && !text_dma_w && !pal_dma_w))
        else begin
            $error("strobes not clear after reset");
            fail_count++;
        end

    a_text_dma_fall: assert property (@(posedge CLK96) disable iff (RESET96)
        $fell(text_dma_w) |-> !$past(tvram_busy))
        else begin
            $error("text_dma_w dropped while tvram busy");
            fail_count++;
        end

    a_pal_dma_fall: assert property (@(posedge CLK96) disable iff (RESET96)
        $fell(pal_dma_w) |-> !$past(tvram_busy))
        else begin
            $error("pal_dma_w dropped while tvram busy");
            fail_count++;
        end

    a_gcu_fall: assert property (@(posedge CLK96) disable iff (RESET96)
        (|($past(gcu_op) & ~gcu_op)) |-> $past(gcu_ack))
        else begin
            $error("gcu op bit dropped without ack");
            fail_count++;
        end

endmodule

//--- test/bus_checker.sv
`timescale 1ns/1ps

module bus_checker (
    input batrider_pkg::data_t   rdata,
    input batrider_pkg::byte_t   slatch,
    input batrider_pkg::byte_t   slatch2,
    input batrider_pkg::gcu_op_t gcu_op,
    input logic                  text_dma_w,
    input logic                  pal_dma_w
);
    import batrider_pkg::*;

    int errors = 0;
    int tests  = 0;

    // kind codes match the testbench table
    task automatic check(input logic [2:0] kind, input data_t exp, input string name);
        data_t got;
        string sig;
        got = '0;
        case (kind)
            3'd1: begin
                got = rdata;
                sig = "rdata";
            end
            3'd2: begin
                got = {8'h00, slatch};
                sig = "slatch";
            end
            3'd3: begin
                got = {8'h00, slatch2};
                sig = "slatch2";
            end
            3'd4: begin
                got = {10'h000, gcu_op};
                sig = "gcu_op";
            end
            3'd5: begin
                got = {15'h0000, text_dma_w};
                sig = "text_dma_w";
            end
            default: begin
                got = {15'h0000, pal_dma_w};
                sig = "pal_dma_w";
            end
        endcase
        tests++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t %s got %h expected %h (%s)", $time, sig, got, exp, name);
        end else begin
            $display("ok    %-16s %s = %h", name, sig, got);
        end
    endtask

    task automatic report();
        $display("tests run %0d, errors %0d", tests, errors);
    endtask

endmodule

//--- test/tb_batrider_bus.sv
`timescale 1ns/1ps

module tb_batrider_bus;
    import batrider_pkg::*;

    typedef struct packed {
        joy_t       joy1;
        joy_t       joy2;
        logic [1:0] start;
        logic [1:0] coin;
        logic       service;
        logic       dip_test;
        byte_t      dipsw_a;
        byte_t      dipsw_b;
        byte_t      dipsw_c;
        video_in_t  video;
        logic       gcu_ack;
        logic       tvram_busy;
    } ports_t;

    typedef struct packed {
        cpu_bus_t   bus;
        ports_t     ports;
        logic [2:0] kind;   // 0 none, 1 rdata, 2 slatch, 3 slatch2, 4 gcu_op, 5 text, 6 pal
        data_t      exp;
    } entry_t;

    // {as, rw, uds, lds}
    localparam logic [3:0] RD = 4'b1111;
    localparam logic [3:0] WW = 4'b1011;
    localparam logic [3:0] WL = 4'b1001;
    localparam logic [3:0] IDLE = 4'b0100;

    logic      CLK96 = 1'b0;
    logic      RESET96 = 1'b1;
    cpu_bus_t  bus = '0;
    data_t     rdata;
    ports_t    p = '0;
    ports_t    drv = '0;
    byte_t     slatch3_in = 8'h3C;
    byte_t     slatch4_in = 8'hC5;
    byte_t     slatch;
    byte_t     slatch2;
    gcu_op_t   gcu_op;
    data_t     gcu_dout = 16'hA5C3;
    logic      text_dma_w;
    logic      pal_dma_w;
    entry_t    table_q[$];
    string     names[$];
    logic      built = 1'b0;
    data_t     d0, d1, d2;

    always #20 CLK96 = ~CLK96;

    batrider_bus batrider_bus_i (
        .CLK96(CLK96), .RESET96(RESET96), .bus(bus), .rdata(rdata),
        .joy1(drv.joy1), .joy2(drv.joy2), .start(drv.start), .coin(drv.coin),
        .service(drv.service), .dip_test(drv.dip_test), .dipsw_a(drv.dipsw_a),
        .dipsw_b(drv.dipsw_b), .dipsw_c(drv.dipsw_c), .video(drv.video),
        .slatch3_in(slatch3_in), .slatch4_in(slatch4_in), .slatch(slatch),
        .slatch2(slatch2), .gcu_op(gcu_op), .gcu_ack(drv.gcu_ack), .gcu_dout(gcu_dout),
        .text_dma_w(text_dma_w), .pal_dma_w(pal_dma_w), .tvram_busy(drv.tvram_busy)
    );

    bus_checker bus_checker_i (
        .rdata(rdata), .slatch(slatch), .slatch2(slatch2),
        .gcu_op(gcu_op), .text_dma_w(text_dma_w), .pal_dma_w(pal_dma_w)
    );

    bind io_regs batrider_bus_props props_i (
        .CLK96(CLK96), .RESET96(RESET96), .gcu_ack(gcu_ack), .tvram_busy(tvram_busy),
        .gcu_op(gcu_op), .text_dma_w(text_dma_w), .pal_dma_w(pal_dma_w)
    );

    task automatic add(input logic [3:0] ctl, input logic [23:0] baddr, input data_t wd,
                       input logic [2:0] kind, input data_t exp, input string name);
        entry_t e;
        e.bus.as    = ctl[3];
        e.bus.rw    = ctl[2];
        e.bus.uds   = ctl[1];
        e.bus.lds   = ctl[0];
        e.bus.addr  = baddr[23:1];
        e.bus.wdata = wd;
        e.ports     = p;    // port settings current at this point of the table
        e.kind      = kind;
        e.exp       = exp;
        table_q.push_back(e);
        names.push_back(name);
    endtask

    initial begin
        void'($urandom(71624));
        d0 = data_t'($urandom);
        d1 = data_t'($urandom);
        d2 = data_t'($urandom);
        p = '{joy1: 7'h7F, joy2: 7'h7F, start: 2'b11, coin: 2'b11, service: 1'b1,
              dip_test: 1'b1, gcu_ack: 1'b1, default: '0};
        add(WW, 24'h200100, d0, 3'd0, 16'h0000, "vram_wr_word");
        add(WW, 24'h208100, d1, 3'd0, 16'h0000, "wram_wr_word");
        add(WL, 24'h200100, d2, 3'd0, 16'h0000, "vram_wr_low");
        add(RD, 24'h200100, 16'h0, 3'd1, {d0[15:8], d2[7:0]}, "vram_readback");
        add(RD, 24'h208100, 16'h0, 3'd1, d1, "wram_readback");
        p.joy1 = 7'b0110101;
        p.joy2 = 7'b1001110;
        p.start = 2'b01;
        p.coin = 2'b10;
        p.service = 1'b0;
        p.dipsw_a = 8'h5A;
        p.dipsw_b = 8'hC3;
        p.dipsw_c = 8'h81;
        add(RD, 24'h500000, 16'h0, 3'd1, 16'h3845, "ctrl_word");
        add(RD, 24'h500002, 16'h0, 3'd1, 16'h8149, "sys_word");
        add(RD, 24'h500004, 16'h0, 3'd1, 16'hC35A, "dsw_ab");
        p.video = '{hsync: 1'b1, vsync: 1'b0, fblank: 1'b1, v: 9'd100};
        add(RD, 24'h500006, 16'h0, 3'd1, 16'hBF64, "vstatus_line100");
        p.video = '{hsync: 1'b0, vsync: 1'b1, fblank: 1'b0, v: 9'd300};
        add(RD, 24'h500006, 16'h0, 3'd1, 16'h7EFF, "vstatus_line300");
        add(WW, 24'h500020, 16'h1234, 3'd2, 16'h0034, "slatch_wr");
        add(WW, 24'h500022, 16'hABCD, 3'd3, 16'h00CD, "slatch2_wr");
        add(WW, 24'h500060, 16'h8001, 3'd0, 16'h0000, "busreq_wr");
        add(RD, 24'h50000C, 16'h0, 3'd1, 16'h8001, "busreq_rd");
        add(RD, 24'h500008, 16'h0, 3'd1, 16'h003C, "slatch3_rd");
        add(RD, 24'h50000A, 16'h0, 3'd1, 16'h00C5, "slatch4_rd");
        p.gcu_ack = 1'b0;
        add(WW, 24'h400004, 16'h0007, 3'd4, 16'h0020, "gcu_select_set");
        add(IDLE, 24'h000000, 16'h0, 3'd4, 16'h0020, "gcu_select_held");
        p.gcu_ack = 1'b1;
        add(IDLE, 24'h000000, 16'h0, 3'd4, 16'h0000, "gcu_select_ack");
        add(RD, 24'h400008, 16'h0, 3'd1, 16'hA5C3, "gcu_ram_h_rd");
        p.tvram_busy = 1'b1;
        add(WW, 24'h500080, 16'h0001, 3'd5, 16'h0001, "text_dma_set");
        add(IDLE, 24'h000000, 16'h0, 3'd5, 16'h0001, "text_dma_held");
        p.tvram_busy = 1'b0;
        add(IDLE, 24'h000000, 16'h0, 3'd5, 16'h0000, "text_dma_clear");
        p.tvram_busy = 1'b1;
        add(WW, 24'h500082, 16'h0001, 3'd6, 16'h0001, "pal_dma_set");
        add(IDLE, 24'h000000, 16'h0, 3'd6, 16'h0001, "pal_dma_held");
        p.tvram_busy = 1'b0;
        add(IDLE, 24'h000000, 16'h0, 3'd6, 16'h0000, "pal_dma_clear");
        add(RD, 24'h300000, 16'h0, 3'd1, 16'h0000, "unmapped_rd");
        built = 1'b1;

        drv <= table_q[0].ports;
        repeat (4) @(posedge CLK96);
        RESET96 <= 1'b0;
        foreach (table_q[i]) begin
            @(posedge CLK96);
            bus <= table_q[i].bus;
            drv <= table_q[i].ports;
            repeat (4) @(posedge CLK96);
            @(negedge CLK96);   // t0+3, outputs settled
            if (table_q[i].kind != 3'd0)
                bus_checker_i.check(table_q[i].kind, table_q[i].exp, names[i]);
            @(posedge CLK96);
            bus.as <= 1'b0;
        end
        @(posedge CLK96);
        bus_checker_i.report();
        if (bus_checker_i.errors == 0 && batrider_bus_i.u_io.props_i.fail_count == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

    // watchdog, scaled by table length
    initial begin
        wait (built);
        #(table_q.size() * 5 * 40 * 2);
        $display("timeout: the test sequence did not finish in time");
        $display("Done: errors found");
        $finish;
    end

endmodule
